//--- design/tmu_pkg.sv
/*
 * Texture-mapping unit pixel path, shared definitions.
 * Widths, CSR block select and register map, and the structs
 * that carry pixels and the job setup between the blocks.
 */
`default_nettype none

package tmu_pkg;

	localparam int FML_DEPTH = 26; // FML byte address width
	localparam int LANES = 4; // RGB565 pixels per 64-bit word

	localparam logic [3:0] CSR_ADDR = 4'h0;

	// Register map, csr_a[2:0]
	localparam logic [2:0] REG_CTRL = 3'd0;
	localparam logic [2:0] REG_BRIGHT = 3'd1;
	localparam logic [2:0] REG_CKEY_EN = 3'd2;
	localparam logic [2:0] REG_CKEY = 3'd3;
	localparam logic [2:0] REG_SRC = 3'd4;
	localparam logic [2:0] REG_DST = 3'd5;
	localparam logic [2:0] REG_COUNT = 3'd6;

	typedef logic [15:0] pixel_t;
	typedef logic [5:0] bright_t;
	typedef logic [FML_DEPTH-4:0] word_adr_t; // 64-bit word address
	typedef logic [15:0] count_t;

	typedef struct packed {
		pixel_t pixel;
		logic valid;
	} lane_in_t;

	typedef struct packed {
		pixel_t pixel;
		logic keep; // Low for a keyed-out pixel
	} lane_out_t;

	typedef struct packed {
		bright_t bright;
		logic ckey_en;
		pixel_t ckey;
		word_adr_t src;
		word_adr_t dst;
		count_t count;
	} job_cfg_t;

endpackage

`default_nettype wire

//--- design/tmu_ctlif.sv
/*
 * TMU control interface.
 * Holds the job registers behind the CSR bus, starts a job on a
 * write of bit 0 to the control register, tracks the busy state
 * until fetch and write-out report done, then pulses the interrupt.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_ctlif (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic [13:0] csr_a_i,
	input  logic csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	output logic irq_o,
	output logic start_o,
	input  logic fetch_done_i,
	input  logic out_done_i,
	output tmu_pkg::job_cfg_t cfg_o
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} state_t;

	state_t state;
	logic csr_sel;
	logic ctrl_go;
	logic busy;

	assign csr_sel = csr_a_i[13:10] == tmu_pkg::CSR_ADDR;
	assign ctrl_go = csr_sel & csr_we_i & (csr_a_i[2:0] == tmu_pkg::REG_CTRL)
		& csr_di_i[0] & (state == IDLE);

	assign busy = state == RUN;
	assign irq_o = state == FINISH; // Busy already low here

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			start_o <= 1'b0;
		end else begin
			start_o <= ctrl_go;
			case (state)
				IDLE: begin
					if (ctrl_go)
						state <= RUN;
				end
				RUN: begin
					// Done levels are stale while start is still high
					if (!start_o && fetch_done_i && out_done_i)
						state <= FINISH;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Register writes
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg_o <= '0;
		end else if (csr_sel && csr_we_i) begin
			case (csr_a_i[2:0])
				tmu_pkg::REG_BRIGHT: cfg_o.bright <= csr_di_i[5:0];
				tmu_pkg::REG_CKEY_EN: cfg_o.ckey_en <= csr_di_i[0];
				tmu_pkg::REG_CKEY: cfg_o.ckey <= csr_di_i[15:0];
				tmu_pkg::REG_SRC: cfg_o.src <= csr_di_i[tmu_pkg::FML_DEPTH-4:0];
				tmu_pkg::REG_DST: cfg_o.dst <= csr_di_i[tmu_pkg::FML_DEPTH-4:0];
				tmu_pkg::REG_COUNT: cfg_o.count <= csr_di_i[15:0];
				default: ;
			endcase
		end
	end

	// Registered read back, other blocks read as zero
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
		end else if (!csr_sel) begin
			csr_do_o <= '0;
		end else begin
			case (csr_a_i[2:0])
				tmu_pkg::REG_CTRL: csr_do_o <= 32'(busy);
				tmu_pkg::REG_BRIGHT: csr_do_o <= 32'(cfg_o.bright);
				tmu_pkg::REG_CKEY_EN: csr_do_o <= 32'(cfg_o.ckey_en);
				tmu_pkg::REG_CKEY: csr_do_o <= 32'(cfg_o.ckey);
				tmu_pkg::REG_SRC: csr_do_o <= 32'(cfg_o.src);
				tmu_pkg::REG_DST: csr_do_o <= 32'(cfg_o.dst);
				tmu_pkg::REG_COUNT: csr_do_o <= 32'(cfg_o.count);
				default: csr_do_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/tmu_pixfetch.sv
/*
 * TMU pixel fetch.
 * Reads consecutive source words over the FML read port into a
 * one-word buffer and hands the four pixels to the decay lanes
 * as soon as the write assembler is free.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_pixfetch (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic start_i,
	input  tmu_pkg::job_cfg_t cfg_i,

	output logic [tmu_pkg::FML_DEPTH-1:0] fmlr_adr_o,
	output logic fmlr_stb_o,
	input  logic fmlr_ack_i,
	input  logic [63:0] fmlr_di_i,

	input  logic pixout_busy_i,
	output tmu_pkg::lane_in_t [tmu_pkg::LANES-1:0] lane_o,
	output logic done_o
);

	tmu_pkg::word_adr_t rd_adr;
	tmu_pkg::count_t rd_left; // Words still to read
	tmu_pkg::count_t hand_left; // Words still to pass to the lanes
	logic buf_full;
	logic [63:0] buf_data;
	logic lane_stb;
	logic hand_off;

	assign fmlr_adr_o = {rd_adr, 3'b000};

	// Word goes to the lanes only while pixout is free
	assign hand_off = buf_full & ~pixout_busy_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlr_stb_o <= 1'b0;
			buf_full <= 1'b0;
			lane_stb <= 1'b0;
			done_o <= 1'b0;
			rd_adr <= '0;
			rd_left <= '0;
			hand_left <= '0;
		end else if (start_i) begin
			fmlr_stb_o <= 1'b0;
			buf_full <= 1'b0;
			lane_stb <= 1'b0;
			done_o <= cfg_i.count == '0;
			rd_adr <= cfg_i.src;
			rd_left <= cfg_i.count;
			hand_left <= cfg_i.count;
		end else begin
			lane_stb <= hand_off;
			if (fmlr_stb_o) begin
				if (fmlr_ack_i) begin // Data valid in the ack cycle
					fmlr_stb_o <= 1'b0;
					buf_full <= 1'b1;
					rd_adr <= rd_adr + 1'b1;
					rd_left <= rd_left - 1'b1;
				end
			end else if (!buf_full && rd_left != '0) begin
				fmlr_stb_o <= 1'b1;
			end
			if (hand_off) begin
				buf_full <= 1'b0;
				hand_left <= hand_left - 1'b1;
				if (hand_left == 16'd1)
					done_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (fmlr_stb_o && fmlr_ack_i)
			buf_data <= fmlr_di_i;
	end

	// Pixel i sits in bits 16i+15..16i
	always_comb begin
		for (int i = 0; i < tmu_pkg::LANES; i++) begin
			lane_o[i].pixel = buf_data[16*i +: 16];
			lane_o[i].valid = lane_stb;
		end
	end

endmodule

`default_nettype wire

//--- design/tmu_decay.sv
/*
 * TMU decay lane.
 * Scales each RGB565 channel by (brightness + 1) / 64 and flags
 * the pixel as dropped when it matches the enabled chroma key.
 * One register stage.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_decay (
	input  logic sys_clk,
	input  logic sys_rst,

	input  tmu_pkg::bright_t bright_i,
	input  logic ckey_en_i,
	input  tmu_pkg::pixel_t ckey_i,

	input  tmu_pkg::lane_in_t lane_i,
	output tmu_pkg::lane_out_t lane_o,
	output logic valid_o
);

	logic [6:0] scale; // 1 to 64
	logic [11:0] r_mul;
	logic [12:0] g_mul;
	logic [11:0] b_mul;
	logic keep;

	assign scale = 7'(bright_i) + 7'd1;

	assign r_mul = 12'(lane_i.pixel[15:11]) * 12'(scale);
	assign g_mul = 13'(lane_i.pixel[10:5]) * 13'(scale);
	assign b_mul = 12'(lane_i.pixel[4:0]) * 12'(scale);

	// Key is compared against the unscaled pixel
	assign keep = ~(ckey_en_i & (lane_i.pixel == ckey_i));

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid_o <= 1'b0;
		else
			valid_o <= lane_i.valid;
	end

	always_ff @(posedge sys_clk) begin
		if (lane_i.valid) begin
			lane_o.pixel <= {r_mul[10:6], g_mul[11:6], b_mul[10:6]};
			lane_o.keep <= keep;
		end
	end

endmodule

`default_nettype wire

//--- design/tmu_pixout.sv
/*
 * TMU write assembler.
 * Packs the four lane results into one 64-bit word, clears the
 * byte selects of dropped pixels and writes the word to the next
 * destination address over the FML write port.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_pixout (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic start_i,
	input  tmu_pkg::job_cfg_t cfg_i,

	input  tmu_pkg::lane_out_t [tmu_pkg::LANES-1:0] lane_i,
	input  logic valid_i,
	output logic pixout_busy_o,

	output logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	input  logic fmlw_ack_i,
	output logic [7:0] fmlw_sel_o,
	output logic [63:0] fmlw_do_o,

	output logic done_o
);

	tmu_pkg::word_adr_t wr_adr;
	tmu_pkg::count_t wr_left; // Writes still to be acked
	logic [63:0] pack_data;
	logic [7:0] pack_sel;

	assign fmlw_adr_o = {wr_adr, 3'b000};

	// Busy from the lane results until the write is acked
	assign pixout_busy_o = valid_i | fmlw_stb_o;

	always_comb begin
		for (int i = 0; i < tmu_pkg::LANES; i++) begin
			pack_data[16*i +: 16] = lane_i[i].pixel;
			pack_sel[2*i +: 2] = {2{lane_i[i].keep}};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlw_stb_o <= 1'b0;
			done_o <= 1'b0;
			wr_adr <= '0;
			wr_left <= '0;
		end else if (start_i) begin
			fmlw_stb_o <= 1'b0;
			done_o <= cfg_i.count == '0;
			wr_adr <= cfg_i.dst;
			wr_left <= cfg_i.count;
		end else begin
			if (valid_i)
				fmlw_stb_o <= 1'b1;
			if (fmlw_stb_o && fmlw_ack_i) begin
				fmlw_stb_o <= 1'b0; // Drops the cycle after ack
				wr_adr <= wr_adr + 1'b1;
				wr_left <= wr_left - 1'b1;
				if (wr_left == 16'd1)
					done_o <= 1'b1;
			end
		end
	end

	// Payload held steady while the strobe waits for ack
	always_ff @(posedge sys_clk) begin
		if (valid_i) begin
			fmlw_do_o <= pack_data;
			fmlw_sel_o <= pack_sel;
		end
	end

endmodule

`default_nettype wire

//--- design/tmu_top.sv
/*
 * TMU pixel post-processing path, top level.
 * Control interface, source fetch, four decay lanes and the
 * write assembler between the FML read and write ports.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_top (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic [13:0] csr_a_i,
	input  logic csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	output logic irq_o,

	output logic [tmu_pkg::FML_DEPTH-1:0] fmlr_adr_o,
	output logic fmlr_stb_o,
	input  logic fmlr_ack_i,
	input  logic [63:0] fmlr_di_i,

	output logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	input  logic fmlw_ack_i,
	output logic [7:0] fmlw_sel_o,
	output logic [63:0] fmlw_do_o
);

	tmu_pkg::job_cfg_t cfg;
	logic start;
	logic fetch_done;
	logic out_done;
	logic pixout_busy;
	tmu_pkg::lane_in_t [tmu_pkg::LANES-1:0] lane_in;
	tmu_pkg::lane_out_t [tmu_pkg::LANES-1:0] lane_out;
	logic [tmu_pkg::LANES-1:0] lane_valid; // All lanes pulse together

	tmu_ctlif i_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.start_o(start),
		.fetch_done_i(fetch_done),
		.out_done_i(out_done),
		.cfg_o(cfg)
	);

	tmu_pixfetch i_pixfetch (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start_i(start),
		.cfg_i(cfg),
		.fmlr_adr_o(fmlr_adr_o),
		.fmlr_stb_o(fmlr_stb_o),
		.fmlr_ack_i(fmlr_ack_i),
		.fmlr_di_i(fmlr_di_i),
		.pixout_busy_i(pixout_busy),
		.lane_o(lane_in),
		.done_o(fetch_done)
	);

	for (genvar i = 0; i < tmu_pkg::LANES; i++) begin : g_lane
		tmu_decay i_decay (
			.sys_clk(sys_clk),
			.sys_rst(sys_rst),
			.bright_i(cfg.bright),
			.ckey_en_i(cfg.ckey_en),
			.ckey_i(cfg.ckey),
			.lane_i(lane_in[i]),
			.lane_o(lane_out[i]),
			.valid_o(lane_valid[i])
		);
	end

	tmu_pixout i_pixout (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start_i(start),
		.cfg_i(cfg),
		.lane_i(lane_out),
		.valid_i(lane_valid[0]),
		.pixout_busy_o(pixout_busy),
		.fmlw_adr_o(fmlw_adr_o),
		.fmlw_stb_o(fmlw_stb_o),
		.fmlw_ack_i(fmlw_ack_i),
		.fmlw_sel_o(fmlw_sel_o),
		.fmlw_do_o(fmlw_do_o),
		.done_o(out_done)
	);

endmodule

`default_nettype wire

//--- sim/tmu_sva.sv
/*
 * TMU bus checks.
 * FML strobe held until ack, dropped after it, address steady
 * while waiting, and a one-cycle interrupt pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_sva (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic stb_i,
	input  logic ack_i,
	input  logic [tmu_pkg::FML_DEPTH-1:0] adr_i,
	input  logic pulse_i
);

	a_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		stb_i && !ack_i |=> stb_i)
		else $error("FML strobe dropped before its ack");

	a_stb_drop: assert property (@(posedge sys_clk) disable iff (sys_rst)
		stb_i && ack_i |=> !stb_i)
		else $error("FML strobe still high after its ack");

	// Address may only move with the ack
	a_adr_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		stb_i && !ack_i |=> $stable(adr_i))
		else $error("FML address changed while waiting for ack");

	a_pulse_one: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pulse_i |=> !pulse_i)
		else $error("interrupt longer than one cycle");

endmodule

bind tmu_pixfetch tmu_sva i_fmlr_sva (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.stb_i(fmlr_stb_o),
	.ack_i(fmlr_ack_i),
	.adr_i(fmlr_adr_o),
	.pulse_i(1'b0)
);

bind tmu_pixout tmu_sva i_fmlw_sva (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.stb_i(fmlw_stb_o),
	.ack_i(fmlw_ack_i),
	.adr_i(fmlw_adr_o),
	.pulse_i(1'b0)
);

bind tmu_ctlif tmu_sva i_irq_sva (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.stb_i(1'b0),
	.ack_i(1'b0),
	.adr_i({tmu_pkg::FML_DEPTH{1'b0}}),
	.pulse_i(irq_o)
);

`default_nettype wire

//--- sim/tb_tmu.sv
/*
 * Testbench for the TMU pixel post-processing path.
 * FML memory model with random ack delays, CSR programming of
 * several jobs, a reference model of the decay and chroma key
 * rules and a check of every write.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tmu;

	localparam int TOTAL_WORDS = 76; // Sum of all job counts
	localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 1000;

	logic sys_clk = 1'b0;
	logic sys_rst;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic irq;
	logic [tmu_pkg::FML_DEPTH-1:0] fmlr_adr;
	logic fmlr_stb;
	logic fmlr_ack = 1'b0;
	logic [63:0] fmlr_di = '0;
	logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr;
	logic fmlw_stb;
	logic fmlw_ack = 1'b0;
	logic [7:0] fmlw_sel;
	logic [63:0] fmlw_do;

	integer seed = 58;
	int rd_wait = 0;
	int wr_wait = 0;
	int wr_max = 3; // Longest write ack delay in cycles
	int rd_total = 0;
	int wr_total = 0;
	int irq_total = 0;
	int rd_base;
	int wr_base;
	int irq_base;
	tmu_pkg::job_cfg_t job;
	logic [31:0] reg_vals [1:6] = '{32'd21, 32'd1, 32'h0000_beef,
		32'h0012_3450, 32'h0054_3210, 32'h0000_0777};

	tmu_top i_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_di_i(csr_di),
		.csr_do_o(csr_do),
		.irq_o(irq),
		.fmlr_adr_o(fmlr_adr),
		.fmlr_stb_o(fmlr_stb),
		.fmlr_ack_i(fmlr_ack),
		.fmlr_di_i(fmlr_di),
		.fmlw_adr_o(fmlw_adr),
		.fmlw_stb_o(fmlw_stb),
		.fmlw_ack_i(fmlw_ack),
		.fmlw_sel_o(fmlw_sel),
		.fmlw_do_o(fmlw_do)
	);

	always #10 sys_clk = ~sys_clk;

	// Source pattern, lane 3 hits key 16'h17e0 every fourth word
	function automatic logic [63:0] mem_word(input tmu_pkg::word_adr_t a);
		logic [15:0] p2;
		p2 = a[15:0] * 16'd37 + {9'd0, a[22:16]};
		return {2'b00, a[1:0], 12'h7e0, p2, {a[22:16], a[8:0]} ^ 16'hc3a5,
			a[15:0] ^ 16'h5a3c};
	endfunction

	// Expected {sel, data} for one source word
	function automatic logic [71:0] expect_word(input logic [63:0] src,
		input tmu_pkg::job_cfg_t cfg);
		logic [63:0] data;
		logic [7:0] sel;
		tmu_pkg::pixel_t p;
		int scale;
		int r;
		int g;
		int b;
		scale = int'(cfg.bright) + 1;
		for (int i = 0; i < tmu_pkg::LANES; i++) begin
			p = src[16*i +: 16];
			r = (int'(p[15:11]) * scale) / 64;
			g = (int'(p[10:5]) * scale) / 64;
			b = (int'(p[4:0]) * scale) / 64;
			data[16*i +: 16] = {r[4:0], g[5:0], b[4:0]};
			sel[2*i +: 2] = (cfg.ckey_en && p == cfg.ckey) ? 2'b00 : 2'b11;
		end
		return {sel, data};
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %0t ns %s expected %h actual %h", $time, name, expected, actual);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic csr_write(input logic [3:0] blk, input logic [2:0] idx,
		input logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= {blk, 7'd0, idx};
		csr_we <= 1'b1;
		csr_di <= data;
		@(posedge sys_clk);
		csr_we <= 1'b0;
	endtask

	// Read data is registered one cycle after the address
	task automatic csr_read(input logic [3:0] blk, input logic [2:0] idx,
		output logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= {blk, 7'd0, idx};
		csr_we <= 1'b0;
		repeat (2) @(posedge sys_clk);
		data = csr_do;
	endtask

	task automatic run_job(input tmu_pkg::bright_t bright, input logic ckey_en,
		input tmu_pkg::pixel_t ckey, input logic [31:0] src, input logic [31:0] dst,
		input int count, input int max_delay);
		logic [31:0] rd_val;
		job.bright = bright;
		job.ckey_en = ckey_en;
		job.ckey = ckey;
		job.src = tmu_pkg::word_adr_t'(src);
		job.dst = tmu_pkg::word_adr_t'(dst);
		job.count = 16'(count);
		wr_max = max_delay;
		rd_base = rd_total;
		wr_base = wr_total;
		irq_base = irq_total;
		csr_write(4'h0, tmu_pkg::REG_BRIGHT, 32'(bright));
		csr_write(4'h0, tmu_pkg::REG_CKEY_EN, 32'(ckey_en));
		csr_write(4'h0, tmu_pkg::REG_CKEY, 32'(ckey));
		csr_write(4'h0, tmu_pkg::REG_SRC, src);
		csr_write(4'h0, tmu_pkg::REG_DST, dst);
		csr_write(4'h0, tmu_pkg::REG_COUNT, 32'(count));
		csr_write(4'h0, tmu_pkg::REG_CTRL, 32'd1);
		csr_read(4'h0, tmu_pkg::REG_CTRL, rd_val);
		check_value("csr_do_o busy in job", 64'd1, 64'(rd_val));
		while (irq_total == irq_base)
			@(posedge sys_clk);
		repeat (4) @(posedge sys_clk); // Catch a second pulse
		check_value("irq_o pulses", 64'd1, 64'(irq_total - irq_base));
		check_value("fmlr reads", 64'(count), 64'(rd_total - rd_base));
		check_value("fmlw writes", 64'(count), 64'(wr_total - wr_base));
		csr_read(4'h0, tmu_pkg::REG_CTRL, rd_val);
		check_value("csr_do_o busy after job", 64'd0, 64'(rd_val));
	endtask

	// FML memory model, one random stream for both ports
	always @(posedge sys_clk) begin
		fmlr_ack <= 1'b0;
		fmlw_ack <= 1'b0;
		if (fmlr_stb && !fmlr_ack) begin
			if (rd_wait == 0) begin
				fmlr_ack <= 1'b1;
				fmlr_di <= mem_word(fmlr_adr[tmu_pkg::FML_DEPTH-1:3]);
				rd_wait <= $unsigned($random(seed)) % 4;
			end else begin
				rd_wait <= rd_wait - 1;
			end
		end
		if (fmlw_stb && !fmlw_ack) begin
			if (wr_wait == 0) begin
				fmlw_ack <= 1'b1;
				wr_wait <= $unsigned($random(seed)) % (wr_max + 1);
			end else begin
				wr_wait <= wr_wait - 1;
			end
		end
	end

	// Reads walk the source words in order
	always @(posedge sys_clk) begin
		if (fmlr_stb && fmlr_ack) begin
			check_value("fmlr_adr_o",
				64'({job.src + tmu_pkg::word_adr_t'(rd_total - rd_base), 3'b000}),
				64'(fmlr_adr));
			rd_total = rd_total + 1;
		end
	end

	// Records each acked write and checks it against the reference
	always @(posedge sys_clk) begin : compare
		logic [71:0] exp_word;
		int idx;
		if (fmlw_stb && fmlw_ack) begin
			idx = wr_total - wr_base;
			assert (idx < int'(job.count)) else begin
				$display("Write at %0t ns goes beyond the job's %0d words", $time, job.count);
				$display("sim failed");
				$fatal(1, "extra write");
			end
			exp_word = expect_word(mem_word(job.src + tmu_pkg::word_adr_t'(idx)), job);
			check_value("fmlw_adr_o",
				64'({job.dst + tmu_pkg::word_adr_t'(idx), 3'b000}), 64'(fmlw_adr));
			check_value("fmlw_do_o", exp_word[63:0], fmlw_do);
			check_value("fmlw_sel_o", 64'(exp_word[71:64]), 64'(fmlw_sel));
			wr_total = wr_total + 1;
		end
	end

	always @(posedge sys_clk) begin
		if (irq) begin
			irq_total = irq_total + 1;
			check_value("fmlw writes at irq_o", 64'(job.count), 64'(wr_total - wr_base));
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Watchdog expired at %0t ns, the job never finished", $time);
		$display("sim failed");
		$fatal(1, "timeout");
	end

	initial begin : main
		logic [31:0] rd_val;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		repeat (8) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);
		check_value("irq_o", 64'd0, 64'(irq));
		check_value("fmlr_stb_o", 64'd0, 64'(fmlr_stb));
		check_value("fmlw_stb_o", 64'd0, 64'(fmlw_stb));
		csr_read(4'h0, tmu_pkg::REG_CTRL, rd_val);
		check_value("csr_do_o busy after reset", 64'd0, 64'(rd_val));

		// Registers hold through accesses to another block
		for (int i = 1; i <= 6; i++)
			csr_write(4'h0, 3'(i), reg_vals[i]);
		for (int i = 1; i <= 6; i++) begin
			csr_write(4'h3, 3'(i), ~reg_vals[i]);
			csr_read(4'h3, 3'(i), rd_val);
		end
		for (int i = 1; i <= 6; i++) begin
			csr_read(4'h0, 3'(i), rd_val);
			check_value($sformatf("csr_do_o reg %0d", i), 64'(reg_vals[i]), 64'(rd_val));
		end

		run_job(6'd63, 1'b0, 16'h0000, 32'h0000_0100, 32'h0000_4000, 8, 3);
		run_job(6'd31, 1'b0, 16'h17e0, 32'h0000_2001, 32'h0000_4100, 8, 3); // Key off
		run_job(6'd0, 1'b0, 16'h0000, 32'h0000_0030, 32'h0000_4200, 8, 3);
		run_job(6'd40, 1'b1, 16'h17e0, 32'h0000_0500, 32'h0000_4300, 12, 3);
		run_job(6'd50, 1'b1, 16'h17e0, 32'h0000_7ff0, 32'h0000_5000, 40, 15);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/tmu_pkg.sv
design/tmu_ctlif.sv
design/tmu_pixfetch.sv
design/tmu_decay.sv
design/tmu_pixout.sv
design/tmu_top.sv
sim/tmu_sva.sv
sim/tb_tmu.sv

//--- Makefile
# Verilator build and run for the TMU pixel path

VERILATOR ?= verilator
TOP ?= tb_tmu
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the output holds the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
